//--- files.f
+incdir+include
src/fifo_pkg.sv
src/uart_pkg.sv
src/fifo_rd_if.sv
src/sync_fifo.sv
src/uart_tx.sv
src/uart_tx_top.sv
verif/uart_tx_checker.sv
verif/uart_tx_tb.sv

//--- include/buf_cfg.svh
`ifndef BUF_CFG_SVH
`define BUF_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// byte buffer
////////////////////////////////////////////////////////////////////////////

`define BUF_DATA_W       8 // byte width
`define BUF_DEPTH        8 // fifo entries
`define BUF_A_FULL_THR   6 // level at or above
`define BUF_A_EMPTY_THR  2 // level at or below

////////////////////////////////////////////////////////////////////////////
// serial line
////////////////////////////////////////////////////////////////////////////

`define TX_CLKS_PER_BIT  4 // clocks per serial bit

`endif

//--- src/fifo_pkg.sv
`default_nettype none

`include "buf_cfg.svh"

package fifo_pkg;

	// entry count, 0 up to full depth
	localparam int unsigned LEVEL_W = $clog2(`BUF_DEPTH + 1);

	typedef logic [LEVEL_W-1:0] fifo_level_t;

endpackage

`default_nettype wire

//--- src/fifo_rd_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "buf_cfg.svh"

// read side of the fifo, head entry always visible (fwft)
interface fifo_rd_if #(
	parameter int DATA_W = `BUF_DATA_W
) ();

	logic              rd_en;   // pop head at next edge
	logic [DATA_W-1:0] rd_data; // current head
	logic              empty;
	logic              a_empty;

	modport fifo_mp (
		input  rd_en,
		output rd_data,
		output empty,
		output a_empty
	);

	modport tx_mp (
		output rd_en,
		input  rd_data,
		input  empty
	);

endinterface

`default_nettype wire

//--- src/sync_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "buf_cfg.svh"

module sync_fifo import fifo_pkg::*; #(
	parameter int DATA_W      = `BUF_DATA_W,
	parameter int DEPTH       = `BUF_DEPTH,
	parameter int A_FULL_THR  = `BUF_A_FULL_THR,
	parameter int A_EMPTY_THR = `BUF_A_EMPTY_THR
) (
	input  logic              clk,
	input  logic              rst_n,

	input  logic              wr_en_i,
	input  logic [DATA_W-1:0] wr_data_i,
	output logic              full_o,
	output logic              a_full_o,
	output fifo_level_t       level_o,

	fifo_rd_if.fifo_mp        rd
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

	////////////////////////////////////////////////////////////////////////////
	// storage and pointers
	////////////////////////////////////////////////////////////////////////////

	logic [DATA_W-1:0] mem [DEPTH];

	logic [PTR_W-1:0] head, head_n; // read side
	logic [PTR_W-1:0] tail, tail_n; // write side
	logic [CNT_W-1:0] cnt, cnt_n;

	logic full, a_full, empty, a_empty;

	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en_i & ~full;  // dropped when full
	assign do_rd = rd.rd_en & ~empty; // ignored when empty

	always_comb begin
		head_n = head;
		tail_n = tail;
		cnt_n  = cnt;

		if (do_rd) begin
			head_n = (head == LAST_PTR) ? '0 : head + 1'b1;
		end

		if (do_wr) begin
			tail_n = (tail == LAST_PTR) ? '0 : tail + 1'b1;
		end

		// both at once leaves the count alone
		case ({do_wr, do_rd})
			2'b10:   cnt_n = cnt + 1'b1;
			2'b01:   cnt_n = cnt - 1'b1;
			default: cnt_n = cnt;
		endcase
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[tail] <= wr_data_i;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// control state and flags
	////////////////////////////////////////////////////////////////////////////

	// flags come from the next count, so they are one cycle behind the strobes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head    <= '0;
			tail    <= '0;
			cnt     <= '0;
			full    <= 1'b0;
			a_full  <= 1'b0;
			empty   <= 1'b1;
			a_empty <= 1'b1;
		end else begin
			head    <= head_n;
			tail    <= tail_n;
			cnt     <= cnt_n;
			full    <= (cnt_n == CNT_W'(DEPTH));
			a_full  <= (cnt_n >= CNT_W'(A_FULL_THR));
			empty   <= (cnt_n == '0);
			a_empty <= (cnt_n <= CNT_W'(A_EMPTY_THR));
		end
	end

	assign rd.rd_data = mem[head];
	assign rd.empty   = empty;
	assign rd.a_empty = a_empty;

	assign full_o   = full;
	assign a_full_o = a_full;
	assign level_o  = fifo_level_t'(cnt);

endmodule

`default_nettype wire

//--- src/uart_pkg.sv
`default_nettype none

package uart_pkg;

	// parity opcode, sampled per frame
	typedef enum logic [1:0] {
		PAR_NONE = 2'd0,
		PAR_EVEN = 2'd1, // total ones even
		PAR_ODD  = 2'd2  // total ones odd
	} parity_e;

	// serializer fsm
	typedef enum logic [2:0] {
		ST_IDLE   = 3'd0,
		ST_START  = 3'd1,
		ST_DATA   = 3'd2,
		ST_PARITY = 3'd3,
		ST_STOP   = 3'd4
	} tx_state_e;

endpackage

`default_nettype wire

//--- src/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

`include "buf_cfg.svh"

module uart_tx import uart_pkg::*; #(
	parameter int DATA_W       = `BUF_DATA_W,
	parameter int CLKS_PER_BIT = `TX_CLKS_PER_BIT
) (
	input  logic       clk,
	input  logic       rst_n,

	input  logic       tx_en_i,  // only looked at in idle
	input  parity_e    parity_i,

	fifo_rd_if.tx_mp   rd,

	output logic       txd_o,
	output logic       busy_o
);

	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam int IDX_W = (DATA_W > 1) ? $clog2(DATA_W) : 1;

	localparam logic [CNT_W-1:0] LAST_CLK = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DATA_W - 1);

	tx_state_e state;

	logic [CNT_W-1:0]  clk_cnt; // clocks within the current bit
	logic [IDX_W-1:0]  bit_idx; // data bit on the line
	logic [DATA_W-1:0] sreg;    // remaining data bits, lsb next
	parity_e           par_mode;
	logic              par_bit;

	logic              txd;
	logic              busy;

	logic              pop;
	logic              bit_end;

	////////////////////////////////////////////////////////////////////////////
	// pop and bit timing
	////////////////////////////////////////////////////////////////////////////

	assign pop     = (state == ST_IDLE) & tx_en_i & ~rd.empty;
	assign bit_end = (clk_cnt == LAST_CLK);

	assign rd.rd_en = pop;

	// byte and parity mode are captured on the pop edge
	always_ff @(posedge clk) begin
		if (pop) begin
			sreg     <= rd.rd_data;
			par_mode <= parity_i;
			par_bit  <= (parity_i == PAR_ODD) ? ~(^rd.rd_data) : ^rd.rd_data;
		end else if (bit_end && (state == ST_START || state == ST_DATA)) begin
			sreg <= sreg >> 1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// frame fsm
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			txd     <= 1'b1; // line idles high
			busy    <= 1'b0;
		end else begin
			if (state == ST_IDLE || bit_end) begin
				clk_cnt <= '0;
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end

			case (state)
				ST_IDLE: begin
					if (pop) begin
						state <= ST_START;
						txd   <= 1'b0; // start bit
						busy  <= 1'b1;
					end
				end

				ST_START: begin
					if (bit_end) begin
						state   <= ST_DATA;
						bit_idx <= '0;
						txd     <= sreg[0];
					end
				end

				ST_DATA: begin
					if (bit_end) begin
						if (bit_idx == LAST_IDX) begin
							if (par_mode == PAR_NONE) begin
								state <= ST_STOP;
								txd   <= 1'b1;
							end else begin
								state <= ST_PARITY;
								txd   <= par_bit;
							end
						end else begin
							bit_idx <= bit_idx + 1'b1;
							txd     <= sreg[0]; // already shifted
						end
					end
				end

				ST_PARITY: begin
					if (bit_end) begin
						state <= ST_STOP;
						txd   <= 1'b1;
					end
				end

				ST_STOP: begin
					if (bit_end) begin
						state <= ST_IDLE; // one idle cycle before next pop
						busy  <= 1'b0;
					end
				end

				default: begin
					state <= ST_IDLE;
					txd   <= 1'b1;
					busy  <= 1'b0;
				end
			endcase
		end
	end

	assign txd_o  = txd;
	assign busy_o = busy;

endmodule

`default_nettype wire

//--- src/uart_tx_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "buf_cfg.svh"

module uart_tx_top import fifo_pkg::*, uart_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,

	// byte input, plain strobe
	input  logic                  wr_en_i,
	input  logic [`BUF_DATA_W-1:0] wr_data_i,

	input  logic                  tx_en_i,
	input  parity_e               parity_i,

	// fifo status
	output logic                  full_o,
	output logic                  a_full_o,
	output logic                  empty_o,
	output logic                  a_empty_o,
	output fifo_level_t           level_o,

	// serial side
	output logic                  txd_o,
	output logic                  busy_o
);

	fifo_rd_if #(
		.DATA_W (`BUF_DATA_W)
	) rd_if ();

	sync_fifo #(
		.DATA_W      (`BUF_DATA_W),
		.DEPTH       (`BUF_DEPTH),
		.A_FULL_THR  (`BUF_A_FULL_THR),
		.A_EMPTY_THR (`BUF_A_EMPTY_THR)
	) fifo_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en_i   (wr_en_i),
		.wr_data_i (wr_data_i),
		.full_o    (full_o),
		.a_full_o  (a_full_o),
		.level_o   (level_o),
		.rd        (rd_if.fifo_mp)
	);

	uart_tx #(
		.DATA_W       (`BUF_DATA_W),
		.CLKS_PER_BIT (`TX_CLKS_PER_BIT)
	) tx_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.tx_en_i  (tx_en_i),
		.parity_i (parity_i),
		.rd       (rd_if.tx_mp),
		.txd_o    (txd_o),
		.busy_o   (busy_o)
	);

	// read side flags straight off the interface
	assign empty_o   = rd_if.empty;
	assign a_empty_o = rd_if.a_empty;

endmodule

`default_nettype wire

//--- verif/uart_tx_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "buf_cfg.svh"

module uart_tx_checker import fifo_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        full_i,
	input  logic        empty_i,
	input  fifo_level_t level_i,
	input  logic        txd_i,
	input  logic        busy_i,
	input  logic        rd_en_i // serializer pop, from inside the top
);

	int fails = 0; // read by the testbench at the end

	a_full_empty: assert property (@(posedge clk) disable iff (!rst_n)
		!(full_i && empty_i))
	else begin
		fails++;
		$error("full and empty are high together");
	end

	a_level_range: assert property (@(posedge clk) disable iff (!rst_n)
		level_i <= `BUF_DEPTH)
	else begin
		fails++;
		$error("fifo level above depth: %0d", level_i);
	end

	// line idles high between frames
	a_idle_line: assert property (@(posedge clk) disable iff (!rst_n)
		!busy_i |-> txd_i)
	else begin
		fails++;
		$error("line low while not busy");
	end

	a_busy_after_pop: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(busy_i) |-> $past(rd_en_i))
	else begin
		fails++;
		$error("busy rose without a pop the cycle before");
	end

endmodule

bind uart_tx_top uart_tx_checker chk_i (
	.clk     (clk),
	.rst_n   (rst_n),
	.full_i  (full_o),
	.empty_i (empty_o),
	.level_i (level_o),
	.txd_i   (txd_o),
	.busy_i  (busy_o),
	.rd_en_i (rd_if.rd_en)
);

`default_nettype wire

//--- verif/uart_tx_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "buf_cfg.svh"

module uart_tx_tb import fifo_pkg::*, uart_pkg::*; ();

	localparam int NUM        = 25;
	localparam int CPB        = `TX_CLKS_PER_BIT;
	localparam int HALF       = CPB / 2;
	localparam int WAIT_LIMIT = 2000;

	logic                   clk;
	logic                   rst_n;
	logic                   wr_en_i;
	logic [`BUF_DATA_W-1:0] wr_data_i;
	logic                   tx_en_i;
	parity_e                parity_i;
	logic                   full_o, a_full_o, empty_o, a_empty_o;
	fifo_level_t            level_o;
	logic                   txd_o, busy_o;

	// stimulus table, one row per write
	logic [7:0] tab_data [NUM];
	parity_e    tab_par  [NUM];
	logic       tab_en   [NUM];
	int         tab_gap  [NUM]; // idle cycles after the write
	logic       tab_acc  [NUM];

	logic [7:0] exp_q [$];
	parity_e    par_q [$];

	int     errors;
	int     timeouts;
	int     model_cnt;
	int     pend_cnt;
	bit     pend_valid;
	integer seed = 32'h49c5f556;

	uart_tx_top dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en_i   (wr_en_i),
		.wr_data_i (wr_data_i),
		.tx_en_i   (tx_en_i),
		.parity_i  (parity_i),
		.full_o    (full_o),
		.a_full_o  (a_full_o),
		.empty_o   (empty_o),
		.a_empty_o (a_empty_o),
		.level_o   (level_o),
		.txd_o     (txd_o),
		.busy_o    (busy_o)
	);

	always #5 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// table and checks
	////////////////////////////////////////////////////////////////////////////

	task automatic build_table;
		int i;
		int cnt;
		cnt = 0;
		for (i = 0; i < NUM; i++) begin
			tab_data[i] = 8'($random(seed));
			tab_par[i]  = (i < 9) ? PAR_EVEN : (i < 17) ? PAR_ODD : PAR_NONE;
			tab_en[i]   = (i >= 9); // first group fills a stopped fifo
			tab_gap[i]  = (i >= 17) ? 3 : 0;
		end
		tab_data[0]  = 8'h00;
		tab_data[1]  = 8'hff;
		tab_data[2]  = 8'h55;
		tab_data[3]  = 8'ha5;
		tab_data[4]  = 8'h01;
		tab_data[5]  = 8'h80;
		tab_data[9]  = 8'h81;
		tab_data[10] = 8'h7e;
		// count restarts at each drain, pops only lower it
		for (i = 0; i < NUM; i++) begin
			if (i > 0 && tab_par[i] != tab_par[i-1]) begin
				cnt = 0;
			end
			tab_acc[i] = (cnt < `BUF_DEPTH);
			if (tab_acc[i]) begin
				cnt++;
			end
		end
	endtask

	task automatic check_flags(input int n);
		assert (level_o == n && full_o == (n == `BUF_DEPTH)
			&& a_full_o == (n >= `BUF_A_FULL_THR) && empty_o == (n == 0)
			&& a_empty_o == (n <= `BUF_A_EMPTY_THR) && txd_o === 1'b1 && busy_o === 1'b0)
		else begin
			errors++;
			$display("Mismatch at %0t: level %0d exp %0d f/af/e/ae %b%b%b%b txd %b busy %b",
				$time, level_o, n, full_o, a_full_o, empty_o, a_empty_o, txd_o, busy_o);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("Error: timed out at %0t waiting for %s", $time, what);
	endtask

	// drive on the rising edge, check the previous write at the falling edge
	task automatic cycle(input logic wr, input int idx);
		@(posedge clk);
		wr_en_i <= wr;
		if (wr) begin
			wr_data_i <= tab_data[idx];
			parity_i  <= tab_par[idx];
			tx_en_i   <= tab_en[idx];
		end
		@(negedge clk);
		if (pend_valid) begin
			check_flags(pend_cnt);
		end
		pend_valid = wr && !tab_en[idx];
		pend_cnt   = model_cnt;
	endtask

	task automatic drain;
		int n;
		cycle(1'b0, 0);
		@(posedge clk);
		tx_en_i <= 1'b1;
		@(negedge clk);
		n = 0;
		while (!(empty_o === 1'b1 && busy_o === 1'b0) && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		assert (n < WAIT_LIMIT) else report_timeout("the FIFO to drain");
		n = 0;
		while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		assert (n < WAIT_LIMIT) else report_timeout("every accepted byte on the line");
		check_flags(0);
		model_cnt = 0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// line decoder
	////////////////////////////////////////////////////////////////////////////

	task automatic decode_frame;
		logic [7:0] got;
		logic [7:0] exp_byte;
		parity_e    mode;
		int         k;
		exp_byte = 8'h00;
		mode     = PAR_NONE;
		repeat (HALF) @(negedge clk); // middle of start bit
		assert (txd_o === 1'b0) else begin
			errors++;
			$display("Mismatch at %0t: start bit reads %b", $time, txd_o);
		end
		for (k = 0; k < 8; k++) begin
			repeat (CPB) @(negedge clk);
			got[k] = txd_o; // lsb first
		end
		assert (exp_q.size() != 0) else begin
			errors++;
			$display("Error: a frame went out at %0t with no accepted byte left", $time);
		end
		if (exp_q.size() != 0) begin
			exp_byte = exp_q.pop_front();
			mode     = par_q.pop_front();
			assert (got === exp_byte) else begin
				errors++;
				$display("Mismatch at %0t: frame data %h, expected %h", $time, got, exp_byte);
			end
		end
		if (mode != PAR_NONE) begin
			repeat (CPB) @(negedge clk);
			// ones in data and parity bit are odd only in odd mode
			assert ((^{exp_byte, txd_o}) === (mode == PAR_ODD)) else begin
				errors++;
				$display("Mismatch at %0t: parity bit %b for %h in mode %s",
					$time, txd_o, exp_byte, mode.name());
			end
		end
		repeat (CPB) @(negedge clk);
		assert (txd_o === 1'b1) else begin
			errors++;
			$display("Mismatch at %0t: stop bit reads %b", $time, txd_o);
		end
	endtask

	initial begin : line_decoder
		logic prev;
		prev = 1'b1;
		forever begin
			@(negedge clk);
			if (rst_n === 1'b1 && prev === 1'b1 && txd_o === 1'b0) begin
				decode_frame();
			end
			prev = txd_o;
		end
	end

	initial begin : main
		int i;
		errors     = 0;
		timeouts   = 0;
		model_cnt  = 0;
		pend_cnt   = 0;
		pend_valid = 1'b0;
		clk        = 1'b0;
		rst_n      = 1'b0;
		wr_en_i    = 1'b0;
		wr_data_i  = '0;
		tx_en_i    = 1'b0;
		parity_i   = PAR_NONE;
		build_table();
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_flags(0);
		for (i = 0; i < NUM; i++) begin
			if (i > 0 && tab_par[i] != tab_par[i-1]) begin
				drain(); // parity mode only changes on an empty, idle line
			end
			if (tab_acc[i]) begin
				model_cnt++;
				exp_q.push_back(tab_data[i]);
				par_q.push_back(tab_par[i]);
			end
			cycle(1'b1, i);
			repeat (tab_gap[i]) cycle(1'b0, 0);
		end
		drain();
		errors += dut_i.chk_i.fails;
		$display("checks done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
